/* hdl/lib_arbiter_pkg.sv */
// Matrix geometry, group layout and hit address widths for the pixel readout arbiter
package lib_arbiter_pkg;

    // ------------------------------
    // Matrix geometry
    // ------------------------------
    localparam int MATRIX_DIM = 4;                         // Pixels per matrix side
    localparam int N_PIXELS   = MATRIX_DIM * MATRIX_DIM;   // Flat request/grant width
    localparam int POLARITY   = 1;                         // Request field, OR of its bits

    // ------------------------------
    // Group layout
    // ------------------------------
    localparam int GROUP_SIZE  = 2;                            // Rows and columns per group
    localparam int GROUP_ADD_W = $clog2(GROUP_SIZE);           // Row/column index in a group
    localparam int GRP_PER_ROW = MATRIX_DIM / GROUP_SIZE;      // Groups along one side
    localparam int N_GROUPS    = GRP_PER_ROW * GRP_PER_ROW;
    localparam int GROUP_W     = $clog2(N_GROUPS);             // Group index width

    // Hit address is {group row, pixel row, group column, pixel column}
    localparam int HIT_ADDR_W = $clog2(N_PIXELS);

endpackage

/* hdl/x_roundrobin.sv */
// Row round-robin arbiter with pointer refresh and group release flag
`timescale 1ns/10ps

module x_roundrobin #(
    parameter int Lvl_ROWS    = 2,
    parameter int Lvl_ROW_ADD = 1
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,    // Row search allowed this cycle
    input  logic                   refresh_i,   // Restart scan from row 0
    input  logic [Lvl_ROWS-1:0]    req_i,       // Rows holding pending hits
    output logic [Lvl_ROWS-1:0]    gnt_o,       // One-hot row grant
    output logic [Lvl_ROW_ADD-1:0] xadd_o,      // Index of last granted row
    output logic                   grp_release  // No requesting row left at or above pointer
);

    logic [Lvl_ROW_ADD:0]   ptr_q;   // Top bit set once the scan passed the last row
    logic [Lvl_ROW_ADD-1:0] pick;    // Lowest requesting row at or above pointer
    logic                   found;

    // Scan from the top so the lowest match is the one left standing
    always_comb
    begin
        pick  = '0;
        found = 1'b0;
        for (int r = Lvl_ROWS - 1; r >= 0; r--)
        begin
            if (req_i[r] && (r >= int'(ptr_q)))
            begin
                pick  = Lvl_ROW_ADD'(r);
                found = 1'b1;
            end
        end
    end

    assign grp_release = ~found;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q  <= '0;
            gnt_o  <= '0;
            xadd_o <= '0;
        end
        else if (refresh_i)
        begin
            ptr_q <= '0;                          // Group lost its enable
            gnt_o <= '0;
        end
        else if (enable_i)
        begin
            gnt_o <= found ? (Lvl_ROWS'(1) << pick) : '0;
            if (found)
                xadd_o <= pick;                   // Held for the column phase
        end
        else if (gnt_o != '0)
        begin
            ptr_q <= {1'b0, xadd_o} + 1'b1;       // Step past the row being served
            gnt_o <= '0;
        end
    end

    a_row_gnt_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("x_roundrobin: more than one row granted");

endmodule

/* hdl/y_roundrobin.sv */
// Column round-robin arbiter issuing single-cycle grants with group release flag
`timescale 1ns/10ps

module y_roundrobin #(
    parameter int Lvl_COLS    = 2,
    parameter int Lvl_COL_ADD = 1
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,    // Column service allowed
    input  logic [Lvl_COLS-1:0]    req_i,       // Column requests of the selected row
    output logic [Lvl_COLS-1:0]    gnt_o,       // One-cycle column grant
    output logic [Lvl_COL_ADD-1:0] yadd_o,      // Index of granted column
    output logic                   grp_release  // Row exhausted from the pointer upward
);

    logic [Lvl_COL_ADD:0]   ptr_q;   // Extra bit lets the pointer sit past the last column
    logic [Lvl_COL_ADD-1:0] pick;
    logic                   found;

    always_comb
    begin
        pick  = '0;
        found = 1'b0;
        for (int c = Lvl_COLS - 1; c >= 0; c--)
        begin
            if (req_i[c] && (c >= int'(ptr_q)))
            begin
                pick  = Lvl_COL_ADD'(c);
                found = 1'b1;
            end
        end
    end

    assign grp_release = ~found;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q  <= '0;
            gnt_o  <= '0;
            yadd_o <= '0;
        end
        else if (enable_i && found)
        begin
            gnt_o  <= Lvl_COLS'(1) << pick;
            yadd_o <= pick;
            ptr_q  <= {1'b0, pick} + 1'b1;        // Granted column is never revisited
        end
        else
        begin
            gnt_o <= '0;
            ptr_q <= '0;                          // Wrap, row done or arbiter idle
        end
    end

    // The granted pixel keeps its request until its grant edge has passed
    a_col_gnt_requested : assert property (@(posedge clk_i) disable iff (reset_i)
        (gnt_o & ~req_i) == '0)
        else $error("y_roundrobin: grant to a column without request");

endmodule

/* hdl/pixel_level.sv */
// 2x2 pixel group FSM driving the row and column round-robin arbiters
`timescale 1ns/10ps

module pixel_level (
    input  logic clk_i,
    input  logic reset_i,
    input  logic enable_i,                                   // Group enable
    input  logic [lib_arbiter_pkg::GROUP_SIZE-1:0][lib_arbiter_pkg::GROUP_SIZE-1:0]
                 [lib_arbiter_pkg::POLARITY-1:0] req_i,      // Pixel requests [row][col]
    output logic [lib_arbiter_pkg::GROUP_SIZE-1:0][lib_arbiter_pkg::GROUP_SIZE-1:0] gnt_o,
    output logic [lib_arbiter_pkg::GROUP_ADD_W-1:0] x_add_o, // Selected row
    output logic [lib_arbiter_pkg::GROUP_ADD_W-1:0] y_add_o, // Selected column
    output logic active_o,                                   // Pixel granted last cycle
    output logic req_o,                                      // Any pending pixel
    output logic grp_release_o                               // Group round finished
);
    import lib_arbiter_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,   // Waiting for enable
        ROW_GRANT = 2'b01,   // Searching for a row
        COL_GRANT = 2'b10    // Serving columns of the held row
    } state_t;

    state_t                current_state;
    state_t                next_state;
    logic [GROUP_SIZE-1:0] row_req;      // Rows with any request
    logic [GROUP_SIZE-1:0] col_req;      // Columns of the selected row
    logic [GROUP_SIZE-1:0] x_gnt;
    logic [GROUP_SIZE-1:0] y_gnt;
    logic                  x_enable;
    logic                  y_enable;
    logic                  refresh;
    logic                  grp_release_x;
    logic                  grp_release_y;

    assign req_o = |req_i;

    always_comb
    begin
        for (int i = 0; i < GROUP_SIZE; i++)
        begin
            row_req[i] = |req_i[i];            // Polarity bits fold into the request
            col_req[i] = |req_i[x_add_o][i];
        end
    end

    // ------------------------------
    // Arbitration FSM
    // ------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            current_state <= IDLE;
        else
            current_state <= next_state;
    end

    always_comb
    begin
        next_state = current_state;
        x_enable   = 1'b0;
        y_enable   = 1'b0;
        refresh    = 1'b0;
        case (current_state)
            IDLE:
            begin
                if (enable_i)
                begin
                    x_enable   = 1'b1;           // Row grant lands next cycle
                    next_state = ROW_GRANT;
                end
            end
            ROW_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh    = 1'b1;           // Restart from row 0 when re-enabled
                    next_state = IDLE;
                end
                else if (x_gnt != '0)
                begin
                    y_enable   = 1'b1;           // Row held, start on its columns
                    next_state = COL_GRANT;
                end
                else
                    x_enable = 1'b1;
            end
            COL_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh    = 1'b1;
                    next_state = IDLE;
                end
                else if (y_gnt == '0)
                begin
                    x_enable   = 1'b1;           // Row empty, look for the next one
                    next_state = ROW_GRANT;
                end
                else
                    y_enable = 1'b1;             // One more column per cycle
            end
            default:
                next_state = IDLE;
        endcase
    end

    // Single pixel grant, withheld while the group is disabled
    always_comb
    begin
        gnt_o = '0;
        if (enable_i && (y_gnt != '0))
            gnt_o[x_add_o][y_add_o] = 1'b1;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            active_o      <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            active_o      <= |gnt_o;
            grp_release_o <= enable_i & grp_release_x & grp_release_y;
        end
    end

    x_roundrobin #(.Lvl_ROWS(GROUP_SIZE), .Lvl_ROW_ADD(GROUP_ADD_W)) u_rr_x (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (x_enable),
        .refresh_i   (refresh),
        .req_i       (row_req),
        .gnt_o       (x_gnt),
        .xadd_o      (x_add_o),
        .grp_release (grp_release_x)
    );

    y_roundrobin #(.Lvl_COLS(GROUP_SIZE), .Lvl_COL_ADD(GROUP_ADD_W)) u_rr_y (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (y_enable),
        .req_i       (col_req),
        .gnt_o       (y_gnt),
        .yadd_o      (y_add_o),
        .grp_release (grp_release_y)
    );

    a_fsm_legal : assert property (@(posedge clk_i) disable iff (reset_i)
        current_state inside {IDLE, ROW_GRANT, COL_GRANT})
        else $error("pixel_level: FSM in unused state encoding");

endmodule

/* hdl/group_arbiter.sv */
// Round-robin selection among pixel groups with release handling and readout back-pressure
`timescale 1ns/10ps

module group_arbiter (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [lib_arbiter_pkg::N_GROUPS-1:0] grp_req_i,      // Group has pending hits
    input  logic [lib_arbiter_pkg::N_GROUPS-1:0] grp_release_i,  // Group finished its round
    input  logic                                 busy_i,         // Readout stalled
    output logic [lib_arbiter_pkg::N_GROUPS-1:0] grp_en_o,       // One-hot or zero
    output logic [lib_arbiter_pkg::GROUP_W-1:0]  grp_sel_o       // Selected group index
);
    import lib_arbiter_pkg::*;

    logic [GROUP_W-1:0]  ptr_q;      // Search start for the next selection
    logic                active_q;   // A group is currently held
    logic                done;
    logic [N_GROUPS-1:0] cand;
    logic [GROUP_W-1:0]  idx;
    logic [GROUP_W-1:0]  pick;
    logic                found;

    assign done = active_q && (grp_release_i[grp_sel_o] || !grp_req_i[grp_sel_o]);

    // Wrapping search from the pointer, finished group left out
    always_comb
    begin
        cand  = grp_req_i;
        pick  = ptr_q;
        found = 1'b0;
        idx   = ptr_q;
        if (done)
            cand[grp_sel_o] = 1'b0;
        for (int k = 0; k < N_GROUPS; k++)
        begin
            idx = ptr_q + GROUP_W'(k);           // Wraps modulo N_GROUPS
            if (!found && cand[idx])
            begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q     <= '0;
            active_q  <= 1'b0;
            grp_sel_o <= '0;
        end
        else if (!active_q || done)
        begin
            active_q <= found;                   // Switch one cycle after release
            if (found)
            begin
                grp_sel_o <= pick;
                ptr_q     <= pick + 1'b1;        // Next round starts past this group
            end
        end
    end

    // Selection is kept while masked, same group resumes after acceptance
    always_comb
    begin
        grp_en_o = '0;
        if (active_q && !busy_i)
            grp_en_o[grp_sel_o] = 1'b1;
    end

    a_grp_en_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grp_en_o))
        else $error("group_arbiter: more than one group enabled");

endmodule

/* hdl/hit_readout.sv */
// Hit address encoder and output register with valid/ready handshake
`timescale 1ns/10ps

module hit_readout (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   grant_valid_i,  // A pixel granted now
    input  logic [lib_arbiter_pkg::GROUP_ADD_W-1:0] x_add_i,       // Pixel row in group
    input  logic [lib_arbiter_pkg::GROUP_ADD_W-1:0] y_add_i,       // Pixel column in group
    input  logic [lib_arbiter_pkg::GROUP_W-1:0]    grp_sel_i,      // Enabled group
    input  logic                                   hit_ready_i,
    output logic                                   hit_valid_o,
    output logic [lib_arbiter_pkg::HIT_ADDR_W-1:0] hit_addr_o,
    output logic                                   busy_o          // Hit held, not taken
);
    import lib_arbiter_pkg::*;

    assign busy_o = hit_valid_o & ~hit_ready_i;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            hit_valid_o <= 1'b0;
        else if (grant_valid_i)
            hit_valid_o <= 1'b1;                 // Valid the cycle after the grant
        else if (hit_ready_i)
            hit_valid_o <= 1'b0;                 // Transfer done, nothing new
    end

    // Group row is the upper index bit, group column the lower
    always_ff @(posedge clk_i)
    begin
        if (grant_valid_i)
            hit_addr_o <= {grp_sel_i[GROUP_W-1], x_add_i, grp_sel_i[0], y_add_i};
    end

    // Group enable masking must keep grants away from a stalled register
    a_no_grant_when_busy : assert property (@(posedge clk_i) disable iff (reset_i)
        grant_valid_i |-> !busy_o)
        else $error("hit_readout: grant while hit is held without ready");

endmodule

/* hdl/pixel_matrix_top.sv */
// Top level of the 4x4 readout arbiter: four pixel groups, group arbiter and hit readout
`timescale 1ns/10ps

module pixel_matrix_top (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic [lib_arbiter_pkg::N_PIXELS-1:0]   pix_req_i,    // Flat index row*4+col
    input  logic                                   hit_ready_i,
    output logic [lib_arbiter_pkg::N_PIXELS-1:0]   pix_gnt_o,
    output logic                                   hit_valid_o,
    output logic [lib_arbiter_pkg::HIT_ADDR_W-1:0] hit_addr_o
);
    import lib_arbiter_pkg::*;

    logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][POLARITY-1:0] grp_pix_req [N_GROUPS];
    logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0]               grp_pix_gnt [N_GROUPS];
    logic [GROUP_ADD_W-1:0]                              grp_x_add   [N_GROUPS];
    logic [GROUP_ADD_W-1:0]                              grp_y_add   [N_GROUPS];
    logic [N_GROUPS-1:0]                                 grp_req;
    logic [N_GROUPS-1:0]                                 grp_release;
    logic [N_GROUPS-1:0]                                 grp_en;
    logic [GROUP_W-1:0]                                  grp_sel;
    logic                                                grant_valid;
    logic                                                busy;

    // ------------------------------
    // Pixel groups
    // ------------------------------
    for (genvar g = 0; g < N_GROUPS; g++)
    begin : g_group
        for (genvar i = 0; i < GROUP_SIZE; i++)
        begin : g_row
            for (genvar j = 0; j < GROUP_SIZE; j++)
            begin : g_col
                localparam int PIX = ((g / GRP_PER_ROW) * GROUP_SIZE + i) * MATRIX_DIM
                                   + (g % GRP_PER_ROW) * GROUP_SIZE + j;
                assign grp_pix_req[g][i][j] = {POLARITY{pix_req_i[PIX]}};
                assign pix_gnt_o[PIX]       = grp_pix_gnt[g][i][j];  // Groups never overlap
            end
        end

        pixel_level u_group (
            .clk_i         (clk_i),
            .reset_i       (reset_i),
            .enable_i      (grp_en[g]),
            .req_i         (grp_pix_req[g]),
            .gnt_o         (grp_pix_gnt[g]),
            .x_add_o       (grp_x_add[g]),
            .y_add_o       (grp_y_add[g]),
            .active_o      (),
            .req_o         (grp_req[g]),
            .grp_release_o (grp_release[g])
        );
    end

    assign grant_valid = |pix_gnt_o;

    group_arbiter u_grp_arb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .grp_req_i     (grp_req),
        .grp_release_i (grp_release),
        .busy_i        (busy),
        .grp_en_o      (grp_en),
        .grp_sel_o     (grp_sel)
    );

    hit_readout u_readout (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .grant_valid_i (grant_valid),
        .x_add_i       (grp_x_add[grp_sel]),   // Only the enabled group can grant
        .y_add_i       (grp_y_add[grp_sel]),
        .grp_sel_i     (grp_sel),
        .hit_ready_i   (hit_ready_i),
        .hit_valid_o   (hit_valid_o),
        .hit_addr_o    (hit_addr_o),
        .busy_o        (busy)
    );

endmodule

/* testbench/tb_pixel_matrix.sv */
// Readout arbiter testbench with pixel model, LFSR stimulus, reference order, checker and timeout
`timescale 1ns/10ps

module tb_pixel_matrix;
    import lib_arbiter_pkg::*;

    typedef logic [HIT_ADDR_W-1:0] addr_list_t [$];

    localparam int N_RANDOM    = 20;                    // Patterns with ready held high
    localparam int N_STALLED   = 10;                    // Patterns with LFSR-driven ready
    localparam int MAX_HITS    = (2 + N_RANDOM + N_STALLED) * N_PIXELS;
    localparam int CYCLE_LIMIT = 40 * MAX_HITS + 500;   // Margin covers reset and idle gaps

    logic                  clk_i;
    logic                  reset_i;
    logic [N_PIXELS-1:0]   pix_req_i   = '0;
    logic                  hit_ready_i = 1'b1;
    logic [N_PIXELS-1:0]   pix_gnt_o;
    logic                  hit_valid_o;
    logic [HIT_ADDR_W-1:0] hit_addr_o;

    logic [16:0]           lfsr_q       = 17'd77205;
    logic [N_PIXELS-1:0]   gnt_seen     = '0;      // Grant sampled mid-cycle
    logic                  random_ready = 1'b0;
    logic                  held_valid   = 1'b0;    // Valid seen without ready last cycle
    logic [HIT_ADDR_W-1:0] held_addr    = '0;
    addr_list_t            exp_q;                  // Hits still owed by the DUT
    int                    grp_ptr      = 0;       // Model of the group round-robin pointer
    int                    chk_errors   = 0;
    int                    flow_errors  = 0;
    int                    hits         = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;
    int                    cycle_cnt    = 0;

    pixel_matrix_top u_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pix_req_i   (pix_req_i),
        .hit_ready_i (hit_ready_i),
        .pix_gnt_o   (pix_gnt_o),
        .hit_valid_o (hit_valid_o),
        .hit_addr_o  (hit_addr_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;                    // 100 ns period
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_bits(input int n, output logic [N_PIXELS-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);                // One step per bit taken
            v      = {v[N_PIXELS-2:0], lfsr_q[0]};
        end
    endtask

    // Groups in wrapping order from the pointer and row-major pixels inside each group
    function automatic addr_list_t expected_order(input logic [N_PIXELS-1:0] pattern,
                                                  input int ptr);
        addr_list_t order;
        int         g;
        int         row;
        int         col;
        order = {};
        for (int k = 0; k < N_GROUPS; k++)
        begin
            g = (ptr + k) % N_GROUPS;
            for (int i = 0; i < GROUP_SIZE; i++)
            begin
                for (int j = 0; j < GROUP_SIZE; j++)
                begin
                    row = (g / GRP_PER_ROW) * GROUP_SIZE + i;
                    col = (g % GRP_PER_ROW) * GROUP_SIZE + j;
                    if (pattern[row * MATRIX_DIM + col])
                        order.push_back({1'(g / GRP_PER_ROW), 1'(i), 1'(g % GRP_PER_ROW), 1'(j)});
                end
            end
        end
        return order;
    endfunction

    // Pixel model and ready source stepped once per clock
    task automatic step_cycle();
        logic [N_PIXELS-1:0] bit_v;
        @(posedge clk_i);
        #1;
        pix_req_i = pix_req_i & ~gnt_seen;            // Request drops on its grant edge
        if (random_ready)
        begin
            draw_bits(1, bit_v);
            hit_ready_i = bit_v[0];
        end
        else
            hit_ready_i = 1'b1;
    endtask

    task automatic run_pattern(input logic [N_PIXELS-1:0] pattern);
        addr_list_t            order;
        logic [HIT_ADDR_W-1:0] last;
        order = expected_order(pattern, grp_ptr);
        foreach (order[k])
            exp_q.push_back(order[k]);
        if (order.size() != 0)
        begin
            last    = order[order.size() - 1];
            grp_ptr = (int'({last[3], last[1]}) + 1) % N_GROUPS;   // Past the last group served
        end
        step_cycle();
        pix_req_i = pix_req_i | pattern;
        while (exp_q.size() != 0)
            step_cycle();
        repeat (8)
            step_cycle();                              // Room for stray extra hits
        assert (pix_req_i == '0)
        else
        begin
            $display("pixels %h still requesting after readout went idle", pix_req_i);
            flow_errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (chk_errors + flow_errors == mark)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, chk_errors + flow_errors - mark);
        end
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------
    always @(negedge clk_i)
    begin
        logic [HIT_ADDR_W-1:0] want;
        gnt_seen = pix_gnt_o;
        if (!reset_i)
        begin
            assert ($onehot0(pix_gnt_o))
            else
            begin
                $display("more than one pixel granted at %0t, pix_gnt_o is %h", $time, pix_gnt_o);
                chk_errors++;
            end
            assert ((pix_gnt_o & ~pix_req_i) == '0)
            else
            begin
                $display("grant at %0t to pixels %h that hold no request",
                         $time, pix_gnt_o & ~pix_req_i);
                chk_errors++;
            end
            if (held_valid)
            begin
                assert (hit_valid_o)
                else
                begin
                    $display("mismatch at %0t: hit_valid_o expected 1 while held, got %b",
                             $time, hit_valid_o);
                    chk_errors++;
                end
                assert (hit_addr_o == held_addr)
                else
                begin
                    $display("mismatch at %0t: hit_addr_o held %h, changed to %h",
                             $time, held_addr, hit_addr_o);
                    chk_errors++;
                end
            end
            if (hit_valid_o && hit_ready_i)            // Transfer on the coming edge
            begin
                hits++;
                assert (exp_q.size() != 0)
                else
                begin
                    $display("hit %h taken at %0t while no hit was pending", hit_addr_o, $time);
                    chk_errors++;
                end
                if (exp_q.size() != 0)
                begin
                    want = exp_q.pop_front();
                    assert (hit_addr_o == want)
                    else
                    begin
                        $display("mismatch at %0t: hit_addr_o expected %h, got %h",
                                 $time, want, hit_addr_o);
                        chk_errors++;
                    end
                end
            end
            held_valid = hit_valid_o && !hit_ready_i;
            held_addr  = hit_addr_o;
        end
    end

    always @(posedge clk_i)
    begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles with %0d hits never delivered",
                     cycle_cnt, exp_q.size());
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin
        logic [N_PIXELS-1:0] pattern;
        int                  mark;
        reset_i = 1'b1;
        repeat (2)
            @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        mark = chk_errors + flow_errors;
        @(negedge clk_i);
        assert (!hit_valid_o)
        else
        begin
            $display("mismatch at %0t: hit_valid_o expected 0, got %b", $time, hit_valid_o);
            flow_errors++;
        end
        assert (pix_gnt_o == '0)
        else
        begin
            $display("mismatch at %0t: pix_gnt_o expected 0000, got %h", $time, pix_gnt_o);
            flow_errors++;
        end
        report_test("reset state", mark);

        mark = chk_errors + flow_errors;
        for (int p = 0; p < N_PIXELS; p++)
            run_pattern(N_PIXELS'(1) << p);
        report_test("single hits", mark);

        mark = chk_errors + flow_errors;
        run_pattern('1);
        report_test("full matrix", mark);

        mark = chk_errors + flow_errors;
        for (int n = 0; n < N_RANDOM; n++)
        begin
            draw_bits(N_PIXELS, pattern);
            run_pattern(pattern);
        end
        report_test("random patterns", mark);

        mark = chk_errors + flow_errors;
        random_ready = 1'b1;                           // Stalls exercise back-pressure
        for (int n = 0; n < N_STALLED; n++)
        begin
            draw_bits(N_PIXELS, pattern);
            run_pattern(pattern);
        end
        random_ready = 1'b0;
        report_test("random ready", mark);

        $display("summary: %0d tests, %0d failing, %0d hits, %0d errors",
                 tests_run, tests_failed, hits, chk_errors + flow_errors);
        if (chk_errors + flow_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* files.f */
hdl/lib_arbiter_pkg.sv
hdl/x_roundrobin.sv
hdl/y_roundrobin.sv
hdl/pixel_level.sv
hdl/group_arbiter.sv
hdl/hit_readout.sv
hdl/pixel_matrix_top.sv
testbench/tb_pixel_matrix.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pixel_matrix -f files.f \
    -o sim_pixel_matrix || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_pixel_matrix)
echo "$out"
echo "$out" | grep -qx "test passed" && echo "PASS" || { echo "FAIL"; exit 1; }
